// File: Makefile
# Verilator build for the debug error logger testbench

VERILATOR  ?= verilator
TOP        ?= tb_err_log
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?=
PASS_MSG   ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/err_csr_pkg.sv
// packed layouts of debug error log registers 1, 3, 4 and 5
`default_nettype none

package err_csr_pkg;

  // log 1 holds the miscompared data, observed in the upper half
  typedef struct packed {
    err_record_pkg::pattern_t observed_pattern;
    err_record_pkg::pattern_t expected_pattern;
  } log1_t;

  // log 3 holds the status bit that software releases, plus where the error was seen
  typedef struct packed {
    logic                    error_status;
    err_record_pkg::loop_t   loop_number;
    err_record_pkg::offset_t byte_offset;
  } log3_t;

  // log 4 describes the address walk of the failing pass
  typedef struct packed {
    err_record_pkg::set_t  set_number;
    err_record_pkg::incr_t address_increment;
  } log4_t;

  // log 5 holds the address of the first error only
  typedef struct packed {
    err_record_pkg::addr_t error_address;
  } log5_t;

endpackage

`default_nettype wire

// File: design/err_log_consts.svh
// width macros for the error logger fields
`ifndef ERR_LOG_CONSTS_SVH
`define ERR_LOG_CONSTS_SVH

// width of the first error address
`define ERR_ADDR_W 64

// observed and expected data patterns
`define ERR_PATTERN_W 32

// loop number reported by either algorithm
`define ERR_LOOP_W 8

// byte offset as held in the log and as reported by algorithm 1b
`define ERR_OFFSET_W 8

// algorithm 1a walks a narrower window and reports a 6-bit offset
`define ERR_ALG1A_OFFSET_W 6

// set number and address increment of the failing pass
`define ERR_SET_W 4
`define ERR_INCR_W 8

`endif

// File: design/err_log_fsm.sv
// capture sequencing state machine with mode gating and record pulses
`default_nettype none

module err_log_fsm (
  input  wire        clk,
  input  wire        reset_n,
  input  wire        i_busy,
  input  wire        i_forceful_disable,
  input  wire        i_writes_only,
  input  wire        i_reads_only,
  input  wire        i_self_check_en,
  input  wire        i_slverr_wr,
  input  wire        i_slverr_rd,
  input  wire        i_poison_rd,
  input  wire        i_status_held,
  err_report_if.sink alg_1a,
  err_report_if.sink alg_1b,
  output logic       o_record_self,
  output logic       o_record_other,
  output logic       o_clear_log,
  output logic       o_record_error
);

  err_record_pkg::log_state_e state;
  err_record_pkg::log_state_e next_state;

  logic blocked;
  logic trig_self_d;
  logic trig_other_d;
  logic trig_self_q;
  logic trig_other_q;

  // nothing is logged while the engine is disabled or runs only writes or only reads
  assign blocked = i_forceful_disable | i_writes_only | i_reads_only;

  // a miscompare wins over a response error seen on the same edge
  assign trig_self_d  = i_busy & ~blocked & i_self_check_en & (alg_1a.found | alg_1b.found);
  assign trig_other_d = i_busy & ~blocked & (i_slverr_wr | i_slverr_rd | i_poison_rd);

  // trigger conditions pass through one register stage before the FSM reacts,
  // so the logs load two edges after the condition is sampled
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      trig_self_q  <= 1'b0;
      trig_other_q <= 1'b0;
    end
    else
    begin
      trig_self_q  <= trig_self_d;
      trig_other_q <= trig_other_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= err_record_pkg::IDLE;
    end
    else if (blocked)
    begin
      state <= err_record_pkg::IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      err_record_pkg::IDLE:
      begin
        if (trig_self_q)
        begin
          next_state = err_record_pkg::RECORD;
        end
        else if (trig_other_q)
        begin
          next_state = err_record_pkg::OTHER;
        end
      end
      err_record_pkg::RECORD:   next_state = err_record_pkg::SEND;
      err_record_pkg::OTHER:    next_state = err_record_pkg::SEND;
      err_record_pkg::SEND:     next_state = err_record_pkg::WAIT;
      // software holds the status bit until it has read the logs
      err_record_pkg::WAIT:
      begin
        if (!i_status_held)
        begin
          next_state = err_record_pkg::COMPLETE;
        end
      end
      err_record_pkg::COMPLETE: next_state = err_record_pkg::IDLE;
      default:                  next_state = err_record_pkg::IDLE;
    endcase
  end

  assign o_record_self  = (state == err_record_pkg::RECORD);
  assign o_record_other = (state == err_record_pkg::OTHER);
  assign o_record_error = (state == err_record_pkg::SEND);

  // the release clears the logs on the same edge that leaves WAIT
  assign o_clear_log = (state == err_record_pkg::WAIT) & ~i_status_held;

endmodule

`default_nettype wire

// File: design/err_log_regs.sv
// log register bank with algorithm priority select, capture and clear
`default_nettype none

module err_log_regs (
  input  wire                clk,
  input  wire                reset_n,
  input  wire                i_set_to_busy,
  input  wire                i_record_self,
  input  wire                i_record_other,
  input  wire                i_clear_log,
  err_report_if.sink         alg_1a,
  err_report_if.sink         alg_1b,
  output err_csr_pkg::log1_t o_log1,
  output err_csr_pkg::log3_t o_log3,
  output err_csr_pkg::log4_t o_log4,
  output err_csr_pkg::log5_t o_log5
);

  logic                     sel_1a;
  logic                     clear;
  err_record_pkg::pattern_t sel_observed;
  err_record_pkg::pattern_t sel_expected;
  err_record_pkg::loop_t    sel_loop;
  err_record_pkg::offset_t  sel_offset;
  err_record_pkg::set_t     sel_set;
  err_record_pkg::incr_t    sel_incr;
  err_record_pkg::addr_t    sel_addr;

  // algorithm 1a has priority when both report in the same cycle
  assign sel_1a = alg_1a.found;

  assign sel_observed = sel_1a ? alg_1a.observed : alg_1b.observed;
  assign sel_expected = sel_1a ? alg_1a.expected : alg_1b.expected;
  assign sel_loop     = sel_1a ? alg_1a.loop     : alg_1b.loop;
  assign sel_offset   = sel_1a ? alg_1a.offset   : alg_1b.offset;
  assign sel_set      = sel_1a ? alg_1a.set      : alg_1b.set;
  assign sel_incr     = sel_1a ? alg_1a.incr     : alg_1b.incr;
  assign sel_addr     = sel_1a ? alg_1a.addr     : alg_1b.addr;

  // a new busy run starts from empty logs, and so does a software release
  assign clear = i_set_to_busy | i_clear_log;

  always_ff @(posedge clk)
  begin
    if (!reset_n || clear)
    begin
      o_log1 <= '0;
    end
    else if (i_record_self)
    begin
      o_log1.observed_pattern <= sel_observed;
      o_log1.expected_pattern <= sel_expected;
    end
  end

  // log 3 is the only register that the other-error path writes
  always_ff @(posedge clk)
  begin
    if (!reset_n || clear)
    begin
      o_log3 <= '0;
    end
    else if (i_record_self)
    begin
      o_log3.error_status <= 1'b1;
      o_log3.loop_number  <= sel_loop;
      o_log3.byte_offset  <= sel_offset;
    end
    else if (i_record_other)
    begin
      // a response error has no data offset and takes its loop from 1b
      o_log3.error_status <= 1'b1;
      o_log3.loop_number  <= alg_1b.loop;
      o_log3.byte_offset  <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || clear)
    begin
      o_log4 <= '0;
    end
    else if (i_record_self)
    begin
      o_log4.set_number        <= sel_set;
      o_log4.address_increment <= sel_incr;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || clear)
    begin
      o_log5 <= '0;
    end
    else if (i_record_self)
    begin
      o_log5.error_address <= sel_addr;
    end
  end

endmodule

`default_nettype wire

// File: design/err_log_top.sv
// debug error logger top level with plain ports, FSM and log register bank
`default_nettype none

`include "err_log_consts.svh"

module err_log_top (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire                          i_busy,
  input  wire                          i_set_to_busy,
  input  wire                          i_forceful_disable,
  input  wire                          i_writes_only,
  input  wire                          i_reads_only,
  input  wire                          i_self_check_en,
  input  wire                          i_slverr_wr,
  input  wire                          i_slverr_rd,
  input  wire                          i_poison_rd,
  input  wire                          i_status_held,
  input  wire                          i_alg_1a_found,
  input  wire [`ERR_PATTERN_W-1:0]     i_alg_1a_observed,
  input  wire [`ERR_PATTERN_W-1:0]     i_alg_1a_expected,
  input  wire [`ERR_LOOP_W-1:0]        i_alg_1a_loop,
  input  wire [`ERR_ALG1A_OFFSET_W-1:0] i_alg_1a_offset,
  input  wire [`ERR_SET_W-1:0]         i_alg_1a_set,
  input  wire [`ERR_INCR_W-1:0]        i_alg_1a_incr,
  input  wire [`ERR_ADDR_W-1:0]        i_alg_1a_addr,
  input  wire                          i_alg_1b_found,
  input  wire [`ERR_PATTERN_W-1:0]     i_alg_1b_observed,
  input  wire [`ERR_PATTERN_W-1:0]     i_alg_1b_expected,
  input  wire [`ERR_LOOP_W-1:0]        i_alg_1b_loop,
  input  wire [`ERR_OFFSET_W-1:0]      i_alg_1b_offset,
  input  wire [`ERR_SET_W-1:0]         i_alg_1b_set,
  input  wire [`ERR_INCR_W-1:0]        i_alg_1b_incr,
  input  wire [`ERR_ADDR_W-1:0]        i_alg_1b_addr,
  output logic [`ERR_PATTERN_W-1:0]    o_observed_pattern,
  output logic [`ERR_PATTERN_W-1:0]    o_expected_pattern,
  output logic                         o_error_status,
  output logic [`ERR_LOOP_W-1:0]       o_loop_number,
  output logic [`ERR_OFFSET_W-1:0]     o_byte_offset,
  output logic [`ERR_SET_W-1:0]        o_set_number,
  output logic [`ERR_INCR_W-1:0]       o_address_increment,
  output logic [`ERR_ADDR_W-1:0]       o_error_address,
  output logic                         o_record_error
);

  logic               record_self;
  logic               record_other;
  logic               clear_log;
  err_csr_pkg::log1_t log1;
  err_csr_pkg::log3_t log3;
  err_csr_pkg::log4_t log4;
  err_csr_pkg::log5_t log5;

  err_report_if alg_1a_rpt ();
  err_report_if alg_1b_rpt ();

  assign alg_1a_rpt.found    = i_alg_1a_found;
  assign alg_1a_rpt.observed = i_alg_1a_observed;
  assign alg_1a_rpt.expected = i_alg_1a_expected;
  assign alg_1a_rpt.loop     = i_alg_1a_loop;
  // widen the 1a offset to the common log width
  assign alg_1a_rpt.offset   = {{(`ERR_OFFSET_W - `ERR_ALG1A_OFFSET_W){1'b0}}, i_alg_1a_offset};
  assign alg_1a_rpt.set      = i_alg_1a_set;
  assign alg_1a_rpt.incr     = i_alg_1a_incr;
  assign alg_1a_rpt.addr     = i_alg_1a_addr;

  assign alg_1b_rpt.found    = i_alg_1b_found;
  assign alg_1b_rpt.observed = i_alg_1b_observed;
  assign alg_1b_rpt.expected = i_alg_1b_expected;
  assign alg_1b_rpt.loop     = i_alg_1b_loop;
  assign alg_1b_rpt.offset   = i_alg_1b_offset;
  assign alg_1b_rpt.set      = i_alg_1b_set;
  assign alg_1b_rpt.incr     = i_alg_1b_incr;
  assign alg_1b_rpt.addr     = i_alg_1b_addr;

  err_log_fsm u_fsm (
    .clk                (clk),
    .reset_n            (reset_n),
    .i_busy             (i_busy),
    .i_forceful_disable (i_forceful_disable),
    .i_writes_only      (i_writes_only),
    .i_reads_only       (i_reads_only),
    .i_self_check_en    (i_self_check_en),
    .i_slverr_wr        (i_slverr_wr),
    .i_slverr_rd        (i_slverr_rd),
    .i_poison_rd        (i_poison_rd),
    .i_status_held      (i_status_held),
    .alg_1a             (alg_1a_rpt.sink),
    .alg_1b             (alg_1b_rpt.sink),
    .o_record_self      (record_self),
    .o_record_other     (record_other),
    .o_clear_log        (clear_log),
    .o_record_error     (o_record_error)
  );

  err_log_regs u_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_set_to_busy  (i_set_to_busy),
    .i_record_self  (record_self),
    .i_record_other (record_other),
    .i_clear_log    (clear_log),
    .alg_1a         (alg_1a_rpt.sink),
    .alg_1b         (alg_1b_rpt.sink),
    .o_log1         (log1),
    .o_log3         (log3),
    .o_log4         (log4),
    .o_log5         (log5)
  );

  assign o_observed_pattern  = log1.observed_pattern;
  assign o_expected_pattern  = log1.expected_pattern;
  assign o_error_status      = log3.error_status;
  assign o_loop_number       = log3.loop_number;
  assign o_byte_offset       = log3.byte_offset;
  assign o_set_number        = log4.set_number;
  assign o_address_increment = log4.address_increment;
  assign o_error_address     = log5.error_address;

endmodule

`default_nettype wire

// File: design/err_record_pkg.sv
// field types of an algorithm error report and the logger state enum
`default_nettype none

`include "err_log_consts.svh"

package err_record_pkg;

  // data compared by the self-check
  typedef logic [`ERR_PATTERN_W-1:0] pattern_t;

  // position of the miscompare within the test run
  typedef logic [`ERR_LOOP_W-1:0]   loop_t;
  typedef logic [`ERR_OFFSET_W-1:0] offset_t;
  typedef logic [`ERR_SET_W-1:0]    set_t;
  typedef logic [`ERR_INCR_W-1:0]   incr_t;
  typedef logic [`ERR_ADDR_W-1:0]   addr_t;

  // capture sequencing states of the logger FSM
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    RECORD   = 3'd1,
    OTHER    = 3'd2,
    SEND     = 3'd3,
    WAIT     = 3'd4,
    COMPLETE = 3'd5
  } log_state_e;

endpackage

`default_nettype wire

// File: design/err_report_if.sv
// interface for one algorithm's self-check error report with source and sink modports
`default_nettype none

interface err_report_if;

  // found is a level, held by the algorithm together with the fields
  logic                     found;
  err_record_pkg::pattern_t observed;
  err_record_pkg::pattern_t expected;
  err_record_pkg::loop_t    loop;
  err_record_pkg::offset_t  offset;
  err_record_pkg::set_t     set;
  err_record_pkg::incr_t    incr;
  err_record_pkg::addr_t    addr;

  // the algorithm side drives the report
  modport source (
    output found, observed, expected, loop, offset, set, incr, addr
  );

  // the logger side only reads it
  modport sink (
    input found, observed, expected, loop, offset, set, incr, addr
  );

endinterface

`default_nettype wire

// File: sim.f
+incdir+design
design/err_record_pkg.sv
design/err_csr_pkg.sv
design/err_report_if.sv
design/err_log_fsm.sv
design/err_log_regs.sv
design/err_log_top.sv
tb/tb_err_log.sv

// File: tb/tb_err_log.sv
// directed tests, LFSR stimulus, check task and cycle timeout for the error logger
`default_nettype none

`include "err_log_consts.svh"

module tb_err_log;

  localparam int MAX_CYCLES = 2000;

  logic                            clk;
  logic                            reset_n;
  logic                            i_busy;
  logic                            i_set_to_busy;
  logic                            i_forceful_disable;
  logic                            i_writes_only;
  logic                            i_reads_only;
  logic                            i_self_check_en;
  logic                            i_slverr_wr;
  logic                            i_slverr_rd;
  logic                            i_poison_rd;
  logic                            i_status_held;
  logic                            i_alg_1a_found;
  logic [`ERR_PATTERN_W-1:0]       i_alg_1a_observed;
  logic [`ERR_PATTERN_W-1:0]       i_alg_1a_expected;
  logic [`ERR_LOOP_W-1:0]          i_alg_1a_loop;
  logic [`ERR_ALG1A_OFFSET_W-1:0]  i_alg_1a_offset;
  logic [`ERR_SET_W-1:0]           i_alg_1a_set;
  logic [`ERR_INCR_W-1:0]          i_alg_1a_incr;
  logic [`ERR_ADDR_W-1:0]          i_alg_1a_addr;
  logic                            i_alg_1b_found;
  logic [`ERR_PATTERN_W-1:0]       i_alg_1b_observed;
  logic [`ERR_PATTERN_W-1:0]       i_alg_1b_expected;
  logic [`ERR_LOOP_W-1:0]          i_alg_1b_loop;
  logic [`ERR_OFFSET_W-1:0]        i_alg_1b_offset;
  logic [`ERR_SET_W-1:0]           i_alg_1b_set;
  logic [`ERR_INCR_W-1:0]          i_alg_1b_incr;
  logic [`ERR_ADDR_W-1:0]          i_alg_1b_addr;
  logic [`ERR_PATTERN_W-1:0]       o_observed_pattern;
  logic [`ERR_PATTERN_W-1:0]       o_expected_pattern;
  logic                            o_error_status;
  logic [`ERR_LOOP_W-1:0]          o_loop_number;
  logic [`ERR_OFFSET_W-1:0]        o_byte_offset;
  logic [`ERR_SET_W-1:0]           o_set_number;
  logic [`ERR_INCR_W-1:0]          o_address_increment;
  logic [`ERR_ADDR_W-1:0]          o_error_address;
  logic                            o_record_error;

  int          error_count;
  int          check_count;
  int          cycle_count;
  logic [31:0] lfsr;

  err_log_top i_err_log_top (.*);

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // fibonacci LFSR with taps 32, 22, 2 and 1
  // each step shifts in the feedback bit, which is also the bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        fb;
    int          i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
      fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr  = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Fail %s at %0t: got %h, expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_logs(input logic [31:0] obs, input logic [31:0] expd, input logic status,
                            input logic [7:0] loop, input logic [7:0] off, input logic [3:0] set,
                            input logic [7:0] incr, input logic [63:0] addr);
    check("o_observed_pattern", 64'(o_observed_pattern), 64'(obs));
    check("o_expected_pattern", 64'(o_expected_pattern), 64'(expd));
    check("o_error_status", 64'(o_error_status), 64'(status));
    check("o_loop_number", 64'(o_loop_number), 64'(loop));
    check("o_byte_offset", 64'(o_byte_offset), 64'(off));
    check("o_set_number", 64'(o_set_number), 64'(set));
    check("o_address_increment", 64'(o_address_increment), 64'(incr));
    check("o_error_address", o_error_address, addr);
  endtask

  task automatic drive_alg_1a();
    logic [31:0] r;
    i_alg_1a_observed = rand_bits(32);
    i_alg_1a_expected = rand_bits(32);
    r = rand_bits(8);
    i_alg_1a_loop = r[7:0];
    r = rand_bits(6);
    i_alg_1a_offset = r[5:0];
    r = rand_bits(4);
    i_alg_1a_set = r[3:0];
    r = rand_bits(8);
    i_alg_1a_incr = r[7:0];
    i_alg_1a_addr = {rand_bits(32), rand_bits(32)};
  endtask

  // bit 6 of the offset is forced so that it lies beyond the reach of algorithm 1a
  task automatic drive_alg_1b();
    logic [31:0] r;
    i_alg_1b_observed = rand_bits(32);
    i_alg_1b_expected = rand_bits(32);
    r = rand_bits(8);
    i_alg_1b_loop = r[7:0];
    r = rand_bits(8);
    i_alg_1b_offset = r[7:0] | 8'h40;
    r = rand_bits(4);
    i_alg_1b_set = r[3:0];
    r = rand_bits(8);
    i_alg_1b_incr = r[7:0];
    i_alg_1b_addr = {rand_bits(32), rand_bits(32)};
  endtask

  task automatic drop_errors();
    i_alg_1a_found = 1'b0;
    i_alg_1b_found = 1'b0;
    i_slverr_wr    = 1'b0;
    i_slverr_rd    = 1'b0;
    i_poison_rd    = 1'b0;
  endtask

  // the trigger is driven ahead of edge k and only the cycle after edge k+2 carries the pulse
  task automatic expect_record_pulse();
    @(negedge clk);
    check("o_record_error", 64'(o_record_error), 64'h0);
    @(negedge clk);
    check("o_record_error", 64'(o_record_error), 64'h0);
    @(negedge clk);
    check("o_record_error", 64'(o_record_error), 64'h1);
    drop_errors();
    @(negedge clk);
    check("o_record_error", 64'(o_record_error), 64'h0);
  endtask

  // software lets go of the status bit and the logs clear on that edge
  task automatic release_status();
    i_status_held = 1'b0;
    @(negedge clk);
    check_logs('0, '0, 1'b0, '0, '0, '0, '0, '0);
    i_status_held = 1'b1;
    @(negedge clk);
  endtask

  task automatic capture_alg_1a();
    drive_alg_1a();
    i_alg_1a_found = 1'b1;
    expect_record_pulse();
    check_logs(i_alg_1a_observed, i_alg_1a_expected, 1'b1, i_alg_1a_loop,
               {2'b00, i_alg_1a_offset}, i_alg_1a_set, i_alg_1a_incr, i_alg_1a_addr);
    release_status();
  endtask

  task automatic priority_between_algs();
    drive_alg_1a();
    drive_alg_1b();
    i_alg_1a_found = 1'b1;
    i_alg_1b_found = 1'b1;
    expect_record_pulse();
    check_logs(i_alg_1a_observed, i_alg_1a_expected, 1'b1, i_alg_1a_loop,
               {2'b00, i_alg_1a_offset}, i_alg_1a_set, i_alg_1a_incr, i_alg_1a_addr);
    release_status();
    drive_alg_1b();
    i_alg_1b_found = 1'b1;
    expect_record_pulse();
    check_logs(i_alg_1b_observed, i_alg_1b_expected, 1'b1, i_alg_1b_loop,
               i_alg_1b_offset, i_alg_1b_set, i_alg_1b_incr, i_alg_1b_addr);
    release_status();
  endtask

  // with self-check off the flag is ignored and the poison strobe takes the other path
  task automatic other_error_path();
    i_self_check_en = 1'b0;
    drive_alg_1a();
    drive_alg_1b();
    i_alg_1a_found = 1'b1;
    i_poison_rd    = 1'b1;
    expect_record_pulse();
    check_logs('0, '0, 1'b1, i_alg_1b_loop, '0, '0, '0, '0);
    release_status();
    i_self_check_en = 1'b1;
  endtask

  task automatic hold_and_busy_clear();
    drive_alg_1a();
    i_alg_1a_found = 1'b1;
    expect_record_pulse();
    repeat (6) @(negedge clk);
    check_logs(i_alg_1a_observed, i_alg_1a_expected, 1'b1, i_alg_1a_loop,
               {2'b00, i_alg_1a_offset}, i_alg_1a_set, i_alg_1a_incr, i_alg_1a_addr);
    release_status();
    drive_alg_1b();
    i_alg_1b_found = 1'b1;
    expect_record_pulse();
    check_logs(i_alg_1b_observed, i_alg_1b_expected, 1'b1, i_alg_1b_loop,
               i_alg_1b_offset, i_alg_1b_set, i_alg_1b_incr, i_alg_1b_addr);
    i_set_to_busy = 1'b1;
    @(negedge clk);
    i_set_to_busy = 1'b0;
    check_logs('0, '0, 1'b0, '0, '0, '0, '0, '0);
    release_status();
  endtask

  // mode 0 drops busy and modes 1 to 3 raise one gate each
  task automatic gated_modes();
    int mode;
    int i;
    for (mode = 0; mode < 4; mode++)
    begin
      i_busy             = (mode != 0);
      i_forceful_disable = (mode == 1);
      i_writes_only      = (mode == 2);
      i_reads_only       = (mode == 3);
      drive_alg_1a();
      i_alg_1a_found = 1'b1;
      i_slverr_wr    = 1'b1;
      for (i = 0; i < 8; i++)
      begin
        @(negedge clk);
        check("o_record_error", 64'(o_record_error), 64'h0);
      end
      drop_errors();
      i_busy             = 1'b1;
      i_forceful_disable = 1'b0;
      i_writes_only      = 1'b0;
      i_reads_only       = 1'b0;
      repeat (3) @(negedge clk);
      check("o_record_error", 64'(o_record_error), 64'h0);
      check_logs('0, '0, 1'b0, '0, '0, '0, '0, '0);
    end
  endtask

  initial
  begin
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    lfsr        = 32'h8a330979;
    clk         = 1'b0;
    reset_n     = 1'b0;
    i_busy             = 1'b0;
    i_set_to_busy      = 1'b0;
    i_forceful_disable = 1'b0;
    i_writes_only      = 1'b0;
    i_reads_only       = 1'b0;
    i_self_check_en    = 1'b0;
    i_status_held      = 1'b0;
    drop_errors();
    i_alg_1a_observed = '0;
    i_alg_1a_expected = '0;
    i_alg_1a_loop     = '0;
    i_alg_1a_offset   = '0;
    i_alg_1a_set      = '0;
    i_alg_1a_incr     = '0;
    i_alg_1a_addr     = '0;
    i_alg_1b_observed = '0;
    i_alg_1b_expected = '0;
    i_alg_1b_loop     = '0;
    i_alg_1b_offset   = '0;
    i_alg_1b_set      = '0;
    i_alg_1b_incr     = '0;
    i_alg_1b_addr     = '0;
    repeat (2) @(negedge clk);
    reset_n = 1'b1;
    check("o_record_error", 64'(o_record_error), 64'h0);
    check_logs('0, '0, 1'b0, '0, '0, '0, '0, '0);
    i_busy          = 1'b1;
    i_self_check_en = 1'b1;
    i_status_held   = 1'b1;
    capture_alg_1a();
    priority_between_algs();
    other_error_path();
    hold_and_busy_clear();
    gated_modes();
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
